//--- Makefile
# Verilator flow for the vector load unit
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TB_TOP    ?= tb_vld_unit
RTL_TOP   ?= vld_unit
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits nonzero on a failing run
run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
hdl/vld_pkg.sv
hdl/vld_insn_queue.sv
hdl/vld_beat_packer.sv
hdl/vld_result_queue.sv
hdl/vld_unit.sv
verification/tb_vld_unit.sv

//--- hdl/vld_beat_packer.sv
/*
 * Packs aligned memory read beats into register-file words across all lanes.
 * Byte b of a word lands in lane b/8 at byte b mod 8.
 */
module vld_beat_packer #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned AxiDataWidth = 64
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Instruction being issued
  input  vld_pkg::vld_insn_t                  issue_insn_i,
  input  logic                                issue_valid_i,
  output logic                                issue_done_o,
  // Memory read data
  input  logic [AxiDataWidth-1:0]             axi_r_data_i,
  input  logic                                axi_r_valid_i,
  output logic                                axi_r_ready_o,
  // Packed word towards the result queue
  output vld_pkg::vld_lane_wr_t [NrLanes-1:0] push_word_o,
  output logic                                push_last_o,
  output logic                                push_valid_o,
  input  logic                                push_ready_i
);

  localparam int unsigned WordBytes = NrLanes * vld_pkg::ElenBytes;
  localparam int unsigned BeatBytes = AxiDataWidth / 8;
  localparam int unsigned PntW      = $clog2(WordBytes + 1);
  localparam int unsigned CntW      = vld_pkg::ByteCntWidth;
  localparam int unsigned AddrW     = vld_pkg::VaddrWidth;

  // Beats must tile a word exactly
  if ((NrLanes * vld_pkg::ElenBits) % AxiDataWidth != 0) begin : g_width_check
    $error("AxiDataWidth does not divide the register-file word width");
  end

  // Bytes still to load that drop to zero between instructions
  logic [CntW-1:0]  rem_q;
  logic [CntW-1:0]  rem_cur;
  logic [CntW-1:0]  rem_next;
  logic [CntW-1:0]  full_bytes;
  // Write position inside the word being built
  logic [PntW-1:0]  byte_pnt_q;
  logic [PntW-1:0]  pnt_next;
  // Word index inside the destination register
  logic [AddrW-1:0] word_off_q;
  logic [AddrW-1:0] word_addr;

  logic [WordBytes-1:0][7:0] data_q;
  logic [WordBytes-1:0][7:0] data_d;
  logic [WordBytes-1:0]      be_q;
  logic [WordBytes-1:0]      be_d;

  logic beat_fire;
  logic word_full;

  // Only take a beat when a finished word could be pushed
  assign axi_r_ready_o = issue_valid_i && push_ready_i;
  assign beat_fire     = axi_r_valid_i && axi_r_ready_o;

  // A fresh instruction starts from its full byte count
  assign full_bytes = CntW'(issue_insn_i.vl) << issue_insn_i.vsew;
  assign rem_cur    = (rem_q == '0) ? full_bytes : rem_q;
  assign rem_next   = (rem_cur < CntW'(BeatBytes)) ? '0 : rem_cur - CntW'(BeatBytes);

  // Aligned beats move the pointer by a whole beat
  assign pnt_next  = byte_pnt_q + PntW'(BeatBytes);
  assign word_full = (pnt_next == PntW'(WordBytes));

  assign issue_done_o = beat_fire && (rem_next == '0);
  assign push_valid_o = beat_fire && (word_full || (rem_next == '0));
  assign push_last_o  = issue_done_o;

  assign word_addr = AddrW'(issue_insn_i.vd) * AddrW'(vld_pkg::WordsPerVreg) + word_off_q;

  //////////////////////////////
  // Byte copy
  //////////////////////////////

  always_comb begin
    data_d = data_q;
    be_d   = be_q;
    if (beat_fire) begin
      for (int unsigned b = 0; b < BeatBytes; b++) begin
        // Clip the tail of the last beat
        if (CntW'(b) < rem_cur) begin
          data_d[int'(byte_pnt_q) + b] = axi_r_data_i[8*b +: 8];
          be_d[int'(byte_pnt_q) + b]   = 1'b1;
        end
      end
    end
  end

  // Split the word into lane writes
  always_comb begin
    for (int unsigned l = 0; l < NrLanes; l++) begin
      push_word_o[l].id   = issue_insn_i.id;
      push_word_o[l].addr = word_addr;
      push_word_o[l].data = data_d[l*vld_pkg::ElenBytes +: vld_pkg::ElenBytes];
      push_word_o[l].be   = be_d[l*vld_pkg::ElenBytes +: vld_pkg::ElenBytes];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q      <= '0;
      byte_pnt_q <= '0;
      word_off_q <= '0;
      be_q       <= '0;
    end else if (beat_fire) begin
      rem_q <= rem_next;
      if (push_valid_o) begin
        // Word leaves this cycle and an empty one starts
        byte_pnt_q <= '0;
        be_q       <= '0;
        word_off_q <= issue_done_o ? '0 : word_off_q + 1'b1;
      end else begin
        byte_pnt_q <= pnt_next;
        be_q       <= be_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      data_q <= push_valid_o ? '0 : data_d;
    end
  end

  // The issuing instruction holds still until its last beat
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rem_q != '0) |-> (issue_valid_i && $stable(issue_insn_i)))
    else $error("issuing instruction changed before its last beat");

endmodule

//--- hdl/vld_insn_queue.sv
/*
 * In-flight load instruction store with accept, issue and commit phases.
 * Reports each instruction done once its last word has been written back.
 */
module vld_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer request
  input  vld_pkg::vld_insn_t   pe_req_i,
  input  logic                 pe_req_valid_i,
  output logic                 pe_req_ready_o,
  // Issue side, towards the beat packer
  output vld_pkg::vld_insn_t   issue_insn_o,
  output logic                 issue_valid_o,
  input  logic                 issue_done_i,
  // Commit side, from the result queue
  input  logic                 commit_last_i,
  // Completion towards the sequencer
  output vld_pkg::vld_done_t   pe_done_o,
  output logic                 load_complete_o
);

  localparam int unsigned PtrW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(InsnQueueDepth + 1);

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  vld_pkg::vld_insn_t insn_q [InsnQueueDepth];

  // One pointer per phase
  logic [PtrW-1:0] accept_pnt_q;
  logic [PtrW-1:0] issue_pnt_q;
  logic [PtrW-1:0] commit_pnt_q;

  // Instructions still to issue, and still to commit
  // Commit count covers the issuing ones too
  logic [CntW-1:0] issue_cnt_q;
  logic [CntW-1:0] commit_cnt_q;

  logic               accept;
  vld_pkg::vld_done_t done_d;

  // Circular pointer step
  function automatic logic [PtrW-1:0] bump(input logic [PtrW-1:0] pnt);
    return (pnt == PtrW'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Full once every slot waits for its commit
  assign pe_req_ready_o = (commit_cnt_q != CntW'(InsnQueueDepth));
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  // Oldest instruction not yet fully issued
  assign issue_insn_o  = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= pe_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= bump(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= bump(issue_pnt_q);
      end
      if (commit_last_i) begin
        commit_pnt_q <= bump(commit_pnt_q);
      end
      // Accept and retire may coincide in one cycle
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(commit_last_i);
    end
  end

  //////////////////////////////
  // Completion
  //////////////////////////////

  // Done bit of the instruction at the commit pointer
  always_comb begin
    done_d = '0;
    if (commit_last_i) begin
      done_d[insn_q[commit_pnt_q].id] = 1'b1;
    end
  end

  // Both completion outputs are registered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_done_o       <= '0;
      load_complete_o <= 1'b0;
    end else begin
      pe_done_o       <= done_d;
      load_complete_o <= commit_last_i;
    end
  end

  // Packer only finishes an instruction this queue handed out
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> (issue_cnt_q != '0))
    else $error("issue done without an issuing instruction");

  // A last word retires only for an instruction past its issue phase
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_last_i |-> (commit_cnt_q > issue_cnt_q))
    else $error("commit of a last word with an empty commit phase");

endmodule

//--- hdl/vld_pkg.sv
/*
 * Shared widths and types of the vector load unit.
 * Every RTL file refers to these by scoped name.
 */
package vld_pkg;

  //////////////////////////////
  // Element and id widths
  //////////////////////////////

  // One lane word holds one 64-bit element slot
  localparam int unsigned ElenBits  = 64;
  localparam int unsigned ElenBytes = ElenBits / 8;

  // Instruction ids, one done bit per id
  localparam int unsigned VidWidth = 3;
  localparam int unsigned NrVInsn  = 2 ** VidWidth;

  // Vector length in elements
  localparam int unsigned VlWidth = 10;

  // Remaining byte count, vl scaled by up to 8 bytes per element
  localparam int unsigned ByteCntWidth = VlWidth + 3;

  //////////////////////////////
  // Register file addressing
  //////////////////////////////

  // Word address inside one lane's register file
  localparam int unsigned VaddrWidth = 12;

  // Destination register index
  localparam int unsigned VdWidth = 5;

  // Words per vector register per lane
  // Register vd starts at vd * WordsPerVreg
  localparam int unsigned WordsPerVreg = 8;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [VidWidth-1:0] vid_t;

  // Element width code, 0..3 for 1, 2, 4 or 8 bytes
  typedef logic [1:0] vsew_t;

  // Load instruction as handed over by the sequencer
  typedef struct packed {
    vid_t               id;
    logic [VdWidth-1:0] vd;
    vsew_t              vsew;
    logic [VlWidth-1:0] vl;
  } vld_insn_t;

  // Write request towards one lane
  typedef struct packed {
    vid_t                  id;
    logic [VaddrWidth-1:0] addr;
    logic [ElenBits-1:0]   data;
    logic [ElenBytes-1:0]  be;
  } vld_lane_wr_t;

  // One bit per instruction id
  typedef logic [NrVInsn-1:0] vld_done_t;

endpackage

//--- hdl/vld_result_queue.sv
/*
 * Buffers packed words and hands them to the lanes.
 * A word retires after every lane granted it and sent its final grant.
 */
module vld_result_queue #(
  parameter int unsigned NrLanes          = 4,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Packed words from the beat packer
  input  vld_pkg::vld_lane_wr_t [NrLanes-1:0] push_word_i,
  input  logic                                push_last_i,
  input  logic                                push_valid_i,
  output logic                                push_ready_o,
  // Lane write ports
  output logic                  [NrLanes-1:0] ldu_req_o,
  output vld_pkg::vld_lane_wr_t [NrLanes-1:0] ldu_wr_o,
  input  logic                  [NrLanes-1:0] ldu_gnt_i,
  input  logic                  [NrLanes-1:0] ldu_final_gnt_i,
  // Last word of an instruction written back
  output logic                                commit_last_o
);

  localparam int unsigned PtrW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);

  //////////////////////////////
  // Word storage
  //////////////////////////////

  vld_pkg::vld_lane_wr_t [NrLanes-1:0] word_q [ResultQueueDepth];
  logic [ResultQueueDepth-1:0]         last_q;

  // Lanes that have not yet granted each entry
  logic [ResultQueueDepth-1:0][NrLanes-1:0] pend_q;

  logic [PtrW-1:0]    wr_pnt_q;
  logic [PtrW-1:0]    rd_pnt_q;
  logic [CntW-1:0]    cnt_q;
  // Final grants gathered for the head word
  logic [NrLanes-1:0] fin_q;
  logic [NrLanes-1:0] fin_seen;

  logic push;
  logic retire;

  assign push_ready_o = (cnt_q != CntW'(ResultQueueDepth));
  assign push         = push_valid_i && push_ready_o;

  // Head word drives the lanes
  assign ldu_req_o = pend_q[rd_pnt_q];
  assign ldu_wr_o  = word_q[rd_pnt_q];

  // Head is done when no lane waits and every lane wrote it back
  assign fin_seen      = fin_q | ldu_final_gnt_i;
  assign retire        = (cnt_q != '0) && (pend_q[rd_pnt_q] == '0) && (&fin_seen);
  assign commit_last_o = retire && last_q[rd_pnt_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      word_q[wr_pnt_q] <= push_word_i;
      last_q[wr_pnt_q] <= push_last_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
      fin_q    <= '0;
    end else begin
      // Grant clears a lane's request
      pend_q[rd_pnt_q] <= pend_q[rd_pnt_q] & ~ldu_gnt_i;
      // New word requests all lanes, later assignment wins on an empty queue
      if (push) begin
        pend_q[wr_pnt_q] <= '1;
        wr_pnt_q <= (wr_pnt_q == PtrW'(ResultQueueDepth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (retire) begin
        rd_pnt_q <= (rd_pnt_q == PtrW'(ResultQueueDepth - 1)) ? '0 : rd_pnt_q + 1'b1;
        fin_q    <= '0;
      end else begin
        fin_q <= fin_seen;
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(retire);
    end
  end

  // Lanes only grant what is requested
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ldu_gnt_i & ~ldu_req_o) == '0)
    else $error("lane grant without a pending request");

endmodule

//--- hdl/vld_unit.sv
/*
 * Vector load unit top level.
 * Connects the instruction queue, the beat packer and the result queue.
 */
module vld_unit #(
  parameter int unsigned NrLanes          = 4,
  parameter int unsigned AxiDataWidth     = 64,
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Sequencer
  input  vld_pkg::vld_insn_t                  pe_req_i,
  input  logic                                pe_req_valid_i,
  output logic                                pe_req_ready_o,
  output vld_pkg::vld_done_t                  pe_done_o,
  output logic                                load_complete_o,
  // Memory read data
  input  logic [AxiDataWidth-1:0]             axi_r_data_i,
  input  logic                                axi_r_valid_i,
  output logic                                axi_r_ready_o,
  // Lanes
  output logic                  [NrLanes-1:0] ldu_req_o,
  output vld_pkg::vld_lane_wr_t [NrLanes-1:0] ldu_wr_o,
  input  logic                  [NrLanes-1:0] ldu_gnt_i,
  input  logic                  [NrLanes-1:0] ldu_final_gnt_i
);

  // Issue handshake
  vld_pkg::vld_insn_t issue_insn;
  logic               issue_valid;
  logic               issue_done;

  // Word push handshake
  vld_pkg::vld_lane_wr_t [NrLanes-1:0] push_word;
  logic                                push_last;
  logic                                push_valid;
  logic                                push_ready;

  logic commit_last;

  vld_insn_queue #(
    .InsnQueueDepth (InsnQueueDepth)
  ) vld_insn_queue_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_req_ready_o  (pe_req_ready_o),
    .issue_insn_o    (issue_insn),
    .issue_valid_o   (issue_valid),
    .issue_done_i    (issue_done),
    .commit_last_i   (commit_last),
    .pe_done_o       (pe_done_o),
    .load_complete_o (load_complete_o)
  );

  vld_beat_packer #(
    .NrLanes      (NrLanes),
    .AxiDataWidth (AxiDataWidth)
  ) vld_beat_packer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .axi_r_data_i  (axi_r_data_i),
    .axi_r_valid_i (axi_r_valid_i),
    .axi_r_ready_o (axi_r_ready_o),
    .push_word_o   (push_word),
    .push_last_o   (push_last),
    .push_valid_o  (push_valid),
    .push_ready_i  (push_ready)
  );

  vld_result_queue #(
    .NrLanes          (NrLanes),
    .ResultQueueDepth (ResultQueueDepth)
  ) vld_result_queue_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_word_i     (push_word),
    .push_last_i     (push_last),
    .push_valid_i    (push_valid),
    .push_ready_o    (push_ready),
    .ldu_req_o       (ldu_req_o),
    .ldu_wr_o        (ldu_wr_o),
    .ldu_gnt_i       (ldu_gnt_i),
    .ldu_final_gnt_i (ldu_final_gnt_i),
    .commit_last_o   (commit_last)
  );

endmodule

//--- verification/tb_vld_unit.sv
/*
 * Testbench for the vector load unit.
 * Sends a fixed set of loads, feeds memory beats, models the lanes and checks with assertions.
 */
module tb_vld_unit;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NrLanes        = 4;
  localparam int InsnQueueDepth = 4;
  localparam int WordBytes      = NrLanes * vld_pkg::ElenBytes;
  localparam int NumInsn        = 6;
  localparam int StallCycles    = 60;
  localparam int WaitLimit      = 1000;

  logic                                clk_i;
  logic                                rst_ni;
  vld_pkg::vld_insn_t                  pe_req_i;
  logic                                pe_req_valid_i;
  logic                                pe_req_ready_o;
  vld_pkg::vld_done_t                  pe_done_o;
  logic                                load_complete_o;
  logic [63:0]                         axi_r_data_i;
  logic                                axi_r_valid_i;
  logic                                axi_r_ready_o;
  logic                  [NrLanes-1:0] ldu_req_o;
  vld_pkg::vld_lane_wr_t [NrLanes-1:0] ldu_wr_o;
  logic                  [NrLanes-1:0] ldu_gnt_i;
  logic                  [NrLanes-1:0] ldu_final_gnt_i;

  // Load list and lookup by id
  vld_pkg::vld_insn_t insn_list [NumInsn];
  vld_pkg::vld_insn_t insn_by_id [vld_pkg::NrVInsn];
  logic               id_known [vld_pkg::NrVInsn];
  // Words each lane has granted, per id
  int                 words_seen [vld_pkg::NrVInsn][NrLanes];
  // Accepted ids still waiting for completion in acceptance order
  vld_pkg::vid_t      done_order [$];
  // Cycles left until a lane's final grant
  int                 fin_wait [NrLanes];

  integer seed = 32'hdaf6_e710;
  int     accept_cnt;
  int     done_cnt;
  int     beats_taken;
  int     beats_allowed;
  logic   saw_full;
  logic   grants_on;

  always #20 clk_i = ~clk_i;

  vld_unit vld_unit_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_req_ready_o  (pe_req_ready_o),
    .pe_done_o       (pe_done_o),
    .load_complete_o (load_complete_o),
    .axi_r_data_i    (axi_r_data_i),
    .axi_r_valid_i   (axi_r_valid_i),
    .axi_r_ready_o   (axi_r_ready_o),
    .ldu_req_o       (ldu_req_o),
    .ldu_wr_o        (ldu_wr_o),
    .ldu_gnt_i       (ldu_gnt_i),
    .ldu_final_gnt_i (ldu_final_gnt_i)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int insn_bytes(input vld_pkg::vld_insn_t insn);
    return int'(insn.vl) << insn.vsew;
  endfunction

  // Byte k of the load with id i in memory
  function automatic logic [7:0] mem_byte(input vld_pkg::vid_t id, input int k);
    return 8'((int'(id) * 32 + k) % 256);
  endfunction

  function automatic logic [63:0] beat_data(input vld_pkg::vid_t id, input int beat);
    logic [63:0] data;
    for (int b = 0; b < 8; b++) begin
      data[8*b +: 8] = mem_byte(id, 8 * beat + b);
    end
    return data;
  endfunction

  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic mismatch(input string msg);
    $display("MISMATCH at %0d ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    stop_with_failure();
  endtask

  // One granted lane write against the memory formula
  task automatic check_lane_write(input int lane, input vld_pkg::vld_lane_wr_t wr);
    vld_pkg::vld_insn_t insn;
    int bytes;
    int word;
    int idx;
    assert (id_known[wr.id])
      else mismatch($sformatf("lane %0d wrote unknown id %0d", lane, wr.id));
    insn  = insn_by_id[wr.id];
    bytes = insn_bytes(insn);
    word  = words_seen[wr.id][lane];
    assert (word * WordBytes < bytes)
      else mismatch($sformatf("lane %0d got an extra word for id %0d", lane, wr.id));
    // Words of one load reach a lane in register order
    assert (int'(wr.addr) == int'(insn.vd) * vld_pkg::WordsPerVreg + word)
      else mismatch($sformatf("lane %0d id %0d addr %0d, word %0d", lane, wr.id, wr.addr,
                              word));
    for (int p = 0; p < vld_pkg::ElenBytes; p++) begin
      idx = word * WordBytes + lane * vld_pkg::ElenBytes + p;
      assert (wr.be[p] == (idx < bytes))
        else mismatch($sformatf("lane %0d id %0d byte %0d enable %b", lane, wr.id, idx,
                                wr.be[p]));
      if (wr.be[p]) begin
        assert (wr.data[8*p +: 8] == mem_byte(wr.id, idx))
          else mismatch($sformatf("lane %0d id %0d byte %0d is %h", lane, wr.id, idx,
                                  wr.data[8*p +: 8]));
      end
    end
    words_seen[wr.id][lane] = word + 1;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic send_insns();
    int tmo;
    for (int n = 0; n < NumInsn; n++) begin
      pe_req_i       = insn_list[n];
      pe_req_valid_i = 1'b1;
      tmo = 0;
      @(posedge clk_i);
      while (!pe_req_ready_o) begin
        tmo++;
        if (tmo > WaitLimit) report_error("timed out waiting for a load to be accepted");
        @(posedge clk_i);
      end
      #2;
    end
    pe_req_valid_i = 1'b0;
  endtask

  // Aligned beats in load order with random gaps between them
  task automatic feed_memory();
    int nbeats;
    int idle;
    int tmo;
    for (int n = 0; n < NumInsn; n++) begin
      nbeats = (insn_bytes(insn_list[n]) + 7) / 8;
      for (int j = 0; j < nbeats; j++) begin
        idle = $unsigned($random(seed)) % 3;
        axi_r_valid_i = 1'b0;
        repeat (idle) begin
          @(posedge clk_i);
          #2;
        end
        axi_r_data_i  = beat_data(insn_list[n].id, j);
        axi_r_valid_i = 1'b1;
        tmo = 0;
        @(posedge clk_i);
        while (!axi_r_ready_o) begin
          tmo++;
          if (tmo > WaitLimit) report_error("timed out waiting for a memory beat to be taken");
          @(posedge clk_i);
        end
        #2;
      end
    end
    axi_r_valid_i = 1'b0;
  endtask

  // Lane model with random grant delay and a final grant 1 to 3 cycles later
  always @(posedge clk_i) begin : lane_model
    logic [NrLanes-1:0] gnt_d;
    logic [NrLanes-1:0] fin_d;
    gnt_d = '0;
    fin_d = '0;
    for (int l = 0; l < NrLanes; l++) begin
      if (rst_ni && ldu_gnt_i[l]) begin
        check_lane_write(l, ldu_wr_o[l]);
        fin_wait[l] = $unsigned($random(seed)) % 3;
        fin_d[l]    = (fin_wait[l] == 0);
      end else if (fin_wait[l] != 0) begin
        fin_wait[l]--;
        fin_d[l] = (fin_wait[l] == 0);
      end else if (rst_ni && grants_on && ldu_req_o[l] && ($random(seed) & 1)) begin
        gnt_d[l] = 1'b1;
      end
    end
    #2;
    ldu_gnt_i       = gnt_d;
    ldu_final_gnt_i = fin_d;
  end

  //////////////////////////////
  // Handshake and completion checks
  //////////////////////////////

  always @(posedge clk_i) begin : monitor
    vld_pkg::vid_t exp_id;
    int            pending;
    if (rst_ni) begin
      assert ((pe_done_o != '0) == load_complete_o)
        else mismatch("pe_done_o and load_complete_o disagree");
      if (load_complete_o) begin
        assert (done_order.size() != 0) else mismatch("completion with no load pending");
        exp_id = done_order.pop_front();
        assert (pe_done_o == (vld_pkg::vld_done_t'(1) << exp_id))
          else mismatch($sformatf("pe_done_o %b, expected id %0d", pe_done_o, exp_id));
        done_cnt++;
      end
      // Ready drops exactly when the queue holds its depth of loads
      pending = accept_cnt - done_cnt;
      assert (pe_req_ready_o == (pending != InsnQueueDepth))
        else mismatch($sformatf("pe_req_ready_o %b with %0d loads pending", pe_req_ready_o,
                                pending));
      if (!pe_req_ready_o) begin
        saw_full = 1'b1;
      end
      assert (!(axi_r_ready_o && (beats_taken == beats_allowed)))
        else mismatch("axi_r_ready_o high with no bytes left to load");
      if (axi_r_valid_i && axi_r_ready_o) begin
        beats_taken++;
      end
      if (pe_req_valid_i && pe_req_ready_o) begin
        done_order.push_back(pe_req_i.id);
        beats_allowed += (insn_bytes(pe_req_i) + 7) / 8;
        accept_cnt++;
      end
    end
  end

  initial begin : main
    int tmo;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    pe_req_i        = '0;
    pe_req_valid_i  = 1'b0;
    axi_r_data_i    = '0;
    axi_r_valid_i   = 1'b0;
    ldu_gnt_i       = '0;
    ldu_final_gnt_i = '0;
    accept_cnt      = 0;
    done_cnt        = 0;
    beats_taken     = 0;
    beats_allowed   = 0;
    saw_full        = 1'b0;
    grants_on       = 1'b0;
    // Exact word, partial last word, partial last beat, every vsew
    insn_list[0] = '{id: 3'd0, vd: 5'd1, vsew: 2'd3, vl: 10'd4};
    insn_list[1] = '{id: 3'd1, vd: 5'd2, vsew: 2'd0, vl: 10'd45};
    insn_list[2] = '{id: 3'd2, vd: 5'd4, vsew: 2'd1, vl: 10'd24};
    insn_list[3] = '{id: 3'd3, vd: 5'd6, vsew: 2'd2, vl: 10'd19};
    insn_list[4] = '{id: 3'd4, vd: 5'd8, vsew: 2'd3, vl: 10'd12};
    insn_list[5] = '{id: 3'd5, vd: 5'd10, vsew: 2'd0, vl: 10'd7};
    for (int i = 0; i < vld_pkg::NrVInsn; i++) begin
      id_known[i] = 1'b0;
    end
    for (int n = 0; n < NumInsn; n++) begin
      insn_by_id[insn_list[n].id] = insn_list[n];
      id_known[insn_list[n].id]   = 1'b1;
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    assert (!axi_r_ready_o && (ldu_req_o == '0) && (pe_done_o == '0) && !load_complete_o
            && pe_req_ready_o)
      else mismatch("outputs not at their idle values after reset");
    #2;
    // Lanes stall at first so both queues fill up
    fork
      send_insns();
      feed_memory();
      begin
        repeat (StallCycles) @(posedge clk_i);
        #2;
        grants_on = 1'b1;
      end
    join
    tmo = 0;
    while (done_cnt < NumInsn) begin
      tmo++;
      if (tmo > WaitLimit) report_error("timed out waiting for all loads to complete");
      @(posedge clk_i);
      #2;
    end
    assert (saw_full) else report_error("instruction queue never filled under back-pressure");
    for (int n = 0; n < NumInsn; n++) begin
      for (int l = 0; l < NrLanes; l++) begin
        assert (words_seen[insn_list[n].id][l] * WordBytes >= insn_bytes(insn_list[n]))
          else report_error($sformatf("lane %0d is missing words of id %0d", l, n));
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule
